/* project.f */
hw/opf_pkg.sv
hw/opf_if.sv
hw/opf_param_regs.sv
hw/opf_sample_timer.sv
hw/opf_input_buffer.sv
hw/opf_chan_sequencer.sv
hw/opf_output_filter.sv
hw/opf_top.sv
tests/opf_props.sv
tests/tb_opf_top.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and decide on the result line in the log
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_opf_top -f project.f > build.log 2>&1 \
    && ./obj_dir/Vtb_opf_top > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "^RESULT: PASS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* tests/tb_opf_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_opf_top;
    import opf_pkg::*;

    logic sys_clk_in;
    logic sys_rst_in;
    logic dv_in;
    logic [w_chan-1:0] chan_in;
    logic signed [w_data_in-1:0] data_in;
    logic [n_chan-1:0] chan_rst_in;
    logic wr_req;
    opf_reg_e wr_sel;
    logic [w_chan-1:0] wr_chan;
    logic [w_wr_data-1:0] wr_data;
    logic wr_ack;
    logic dv_out;
    logic [w_chan-1:0] chan_out;
    logic signed [w_data_out-1:0] data_out;

    integer seed = 32'h656b;
    int mismatches = 0;
    int other_errors = 0;
    int perm [n_chan];
    // Reference model state per channel
    longint m_mult [n_chan];
    longint m_rs [n_chan];
    longint m_max [n_chan];
    longint m_min [n_chan];
    longint m_init [n_chan];
    longint m_prev [n_chan];
    // Outstanding expectations
    bit [n_chan-1:0] exp_pend;
    longint exp_val [n_chan];
    longint last_out [n_chan];
    // Captured outputs
    int out_chan_q [$];
    longint out_data_q [$];

    opf_top UUT (
        .sys_clk_in (sys_clk_in), .sys_rst_in (sys_rst_in),
        .dv_in (dv_in), .chan_in (chan_in), .data_in (data_in),
        .chan_rst_in (chan_rst_in),
        .wr_req (wr_req), .wr_sel (wr_sel), .wr_chan (wr_chan),
        .wr_data (wr_data), .wr_ack (wr_ack),
        .dv_out (dv_out), .chan_out (chan_out), .data_out (data_out)
    );

    initial begin
        sys_clk_in = 1'b0;
        forever #4 sys_clk_in = ~sys_clk_in;
    end

    // Output capture, registered outputs seen before the edge updates them
    always @(posedge sys_clk_in) begin
        if (!sys_rst_in && dv_out) begin
            out_chan_q.push_back(int'(chan_out));
            out_data_q.push_back(longint'(data_out));
        end
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // Random order of all channels
    function automatic void shuffle_chans();
        int j;
        int t;
        for (int i = n_chan - 1; i > 0; i--) begin
            j = rand_range(0, i);
            t = perm[i];
            perm[i] = perm[j];
            perm[j] = t;
        end
    endfunction

    // Scale, accumulate, clamp
    function automatic longint model_update(input int ch, input longint din);
        longint sum;
        sum = ((din * m_mult[ch]) >>> m_rs[ch]) + m_prev[ch];
        if (sum > m_max[ch]) begin
            sum = m_max[ch];
        end else if (sum < m_min[ch]) begin
            sum = m_min[ch];
        end
        return sum;
    endfunction

    task automatic check_val(input string name, input longint exp, input longint act);
        if (exp !== act) begin
            mismatches++;
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    // ------------------------------
    // Host write, four-phase
    // ------------------------------
    task automatic write_param(input opf_reg_e sel, input int ch, input logic [w_wr_data-1:0] val);
        int n;
        wr_sel = sel;
        wr_chan = w_chan'(ch);
        wr_data = val;
        wr_req = 1'b1;
        n = 0;
        @(negedge sys_clk_in);
        while (!wr_ack && n < 20) begin
            @(negedge sys_clk_in);
            n++;
        end
        if (!wr_ack) begin
            other_errors++;
            $display("Timeout at %0t: wr_ack never rose", $time);
        end
        wr_req = 1'b0;
        n = 0;
        while (wr_ack && n < 20) begin
            @(negedge sys_clk_in);
            n++;
        end
        if (wr_ack) begin
            other_errors++;
            $display("Timeout at %0t: wr_ack stuck high", $time);
        end
        case (sel)
            reg_mult: m_mult[ch] = longint'($signed(val[w_mult-1:0]));
            reg_rs:   m_rs[ch] = longint'(val[w_rs-1:0]);
            reg_max:  m_max[ch] = longint'($signed(val));
            reg_min:  m_min[ch] = longint'($signed(val));
            reg_init: m_init[ch] = longint'($signed(val));
            default: ;
        endcase
    endtask

    // ------------------------------
    // Samples and outputs
    // ------------------------------
    task automatic drive_sample(input int ch, input longint d);
        dv_in = 1'b1;
        chan_in = w_chan'(ch);
        data_in = w_data_in'(d);
        @(negedge sys_clk_in);
    endtask

    function automatic void expect_sample(input int ch, input longint d);
        exp_val[ch] = model_update(ch, d);
        exp_pend[ch] = 1'b1;
        m_prev[ch] = exp_val[ch];
    endfunction

    // Match one captured output by its channel
    task automatic take_output();
        int ch;
        longint val;
        ch = out_chan_q.pop_front();
        val = out_data_q.pop_front();
        if (!exp_pend[ch]) begin
            other_errors++;
            $display("Unexpected output on channel %0d at %0t", ch, $time);
        end else begin
            check_val($sformatf("data_out[ch %0d]", ch), exp_val[ch], val);
            exp_pend[ch] = 1'b0;
            last_out[ch] = val;
        end
    endtask

    task automatic collect_outputs(input int count);
        int waited;
        waited = 0;
        while (out_chan_q.size() < count && waited < 4 * tick_period) begin
            @(negedge sys_clk_in);
            waited++;
        end
        if (out_chan_q.size() < count) begin
            other_errors++;
            $display("Timeout at %0t: only %0d of %0d outputs arrived",
                     $time, out_chan_q.size(), count);
        end
        while (out_chan_q.size() > 0) begin
            take_output();
        end
        // Drop expectations that never got an output
        exp_pend = '0;
    endtask

    // Mode: 0 random, 1 large positive, -1 large negative
    task automatic sample_phase(input int count, input int mode);
        longint d;
        shuffle_chans();
        for (int i = 0; i < count; i++) begin
            if (mode > 0) begin
                d = rand_range(1000, 2000);
            end else if (mode < 0) begin
                d = -rand_range(1000, 2000);
            end else begin
                d = rand_range(-131072, 131071);
            end
            expect_sample(perm[i], d);
            drive_sample(perm[i], d);
        end
        dv_in = 1'b0;
        collect_outputs(count);
    endtask

    task automatic single_sample(input int ch, input longint d);
        expect_sample(ch, d);
        drive_sample(ch, d);
        dv_in = 1'b0;
        collect_outputs(1);
    endtask

    // Back-to-back samples, one or two outputs allowed
    task automatic pair_test(input int ch);
        longint a;
        longint b;
        int waited;
        a = rand_range(-131072, 131071);
        b = rand_range(-131072, 131071);
        drive_sample(ch, a);
        drive_sample(ch, b);
        dv_in = 1'b0;
        waited = 0;
        while (out_chan_q.size() < 2 && waited < 4 * tick_period) begin
            @(negedge sys_clk_in);
            waited++;
        end
        if (out_chan_q.size() == 2) begin
            // First sample got issued before the second replaced it
            expect_sample(ch, a);
            take_output();
            expect_sample(ch, b);
            take_output();
        end else if (out_chan_q.size() == 1) begin
            expect_sample(ch, b);
            take_output();
        end else begin
            other_errors++;
            $display("No output for back-to-back samples on channel %0d", ch);
        end
        exp_pend = '0;
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int c;
        dv_in = 1'b0;
        chan_in = '0;
        data_in = '0;
        chan_rst_in = '0;
        wr_req = 1'b0;
        wr_sel = reg_mult;
        wr_chan = '0;
        wr_data = '0;
        exp_pend = '0;
        for (int i = 0; i < n_chan; i++) begin
            perm[i] = i;
            m_mult[i] = 1;
            m_rs[i] = 0;
            m_max[i] = longint'(max_out);
            m_min[i] = longint'(min_out);
            m_init[i] = 0;
            m_prev[i] = 0;
            last_out[i] = 0;
        end
        sys_rst_in = 1'b1;
        repeat (8) @(negedge sys_clk_in);
        sys_rst_in = 1'b0;
        @(negedge sys_clk_in);
        check_val("dv_out", 0, longint'(dv_out));
        check_val("wr_ack", 0, longint'(wr_ack));

        // Defaults pass samples through unchanged
        sample_phase(n_chan, 0);
        sample_phase(rand_range(1, n_chan), 0);

        // Random multiplier and shift, raw 24-bit words get truncated
        for (int i = 0; i < n_chan; i++) begin
            write_param(reg_mult, i, w_wr_data'($random(seed)));
            write_param(reg_rs, i, w_wr_data'($random(seed)));
        end
        repeat (4) sample_phase(rand_range(1, n_chan), 0);

        // Narrow bounds
        for (int i = 0; i < n_chan; i++) begin
            write_param(reg_mult, i, w_wr_data'(rand_range(1, 3)));
            write_param(reg_rs, i, '0);
            write_param(reg_max, i, w_wr_data'(rand_range(200, 700)));
            write_param(reg_min, i, w_wr_data'(rand_range(-700, -200)));
        end
        repeat (3) sample_phase(n_chan, 1);
        for (int i = 0; i < n_chan; i++) begin
            check_val($sformatf("data_out[ch %0d] at max", i), m_max[i], last_out[i]);
        end
        repeat (3) sample_phase(n_chan, -1);
        for (int i = 0; i < n_chan; i++) begin
            check_val($sformatf("data_out[ch %0d] at min", i), m_min[i], last_out[i]);
        end

        // Channel reset loads init, then accumulation resumes from it
        for (int i = 0; i < n_chan; i++) begin
            write_param(reg_max, i, w_wr_data'(max_out));
            write_param(reg_min, i, w_wr_data'(min_out));
        end
        for (int k = 0; k < 4; k++) begin
            c = rand_range(0, n_chan - 1);
            write_param(reg_init, c, w_wr_data'(rand_range(-(1 << 20), 1 << 20)));
            exp_val[c] = m_init[c];
            exp_pend[c] = 1'b1;
            m_prev[c] = m_init[c];
            chan_rst_in[c] = 1'b1;
            @(negedge sys_clk_in);
            chan_rst_in = '0;
            collect_outputs(1);
            single_sample(c, rand_range(-4096, 4096));
        end

        // Back-to-back pairs at random points in the tick period
        for (int k = 0; k < 6; k++) begin
            c = rand_range(0, n_chan - 1);
            repeat (rand_range(0, tick_period - 1)) @(negedge sys_clk_in);
            pair_test(c);
            single_sample(c, rand_range(-131072, 131071));
        end

        // Nothing further may come out
        repeat (3 * tick_period) @(negedge sys_clk_in);
        if (out_chan_q.size() != 0) begin
            other_errors++;
            $display("%0d extra outputs after the last phase", out_chan_q.size());
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/opf_props.sv */
`timescale 1ns/1ps
`default_nettype none

module opf_props (
    input wire sys_clk_in,
    input wire sys_rst_in,
    input wire wr_req,
    input wire wr_ack,
    input wire dv_out
);
    // Ack only answers a request
    ack_rise_with_req: assert property (@(posedge sys_clk_in) disable iff (sys_rst_in)
        $rose(wr_ack) |-> $past(wr_req))
        else $error("wr_ack rose without wr_req");

    // Host holds the request until the ack
    req_held_to_ack: assert property (@(posedge sys_clk_in) disable iff (sys_rst_in)
        $fell(wr_req) |-> wr_ack)
        else $error("wr_req dropped before wr_ack");

    // Ack released only after the request is gone
    ack_fall_after_req: assert property (@(posedge sys_clk_in) disable iff (sys_rst_in)
        $fell(wr_ack) |-> $past(!wr_req))
        else $error("wr_ack fell while wr_req was high");

    dv_out_known: assert property (@(posedge sys_clk_in) disable iff (sys_rst_in)
        !$isunknown(dv_out))
        else $error("dv_out is unknown");

endmodule

bind opf_top opf_props u_props (
    .sys_clk_in (sys_clk_in),
    .sys_rst_in (sys_rst_in),
    .wr_req     (wr_req),
    .wr_ack     (wr_ack),
    .dv_out     (dv_out)
);

`default_nettype wire

/* hw/opf_top.sv */
`timescale 1ns/1ps
`default_nettype none

module opf_top (
    input  wire                                  sys_clk_in,
    input  wire                                  sys_rst_in,
    // Sample stream in
    input  wire                                  dv_in,
    input  wire [opf_pkg::w_chan-1:0]            chan_in,
    input  wire signed [opf_pkg::w_data_in-1:0]  data_in,
    // Channel reset requests
    input  wire [opf_pkg::n_chan-1:0]            chan_rst_in,
    // Host settings write
    input  wire                                  wr_req,
    input  opf_pkg::opf_reg_e                    wr_sel,
    input  wire [opf_pkg::w_chan-1:0]            wr_chan,
    input  wire [opf_pkg::w_wr_data-1:0]         wr_data,
    output logic                                 wr_ack,
    // Output stream
    output logic                                 dv_out,
    output logic [opf_pkg::w_chan-1:0]           chan_out,
    output logic signed [opf_pkg::w_data_out-1:0] data_out
);
    import opf_pkg::*;

    logic tick;
    logic [n_chan-1:0] pending;

    // Issue path and settings lookup
    opf_issue_if issue ();
    opf_cfg_if cfg ();

    opf_param_regs u_param_regs (
        .sys_clk_in (sys_clk_in),
        .sys_rst_in (sys_rst_in),
        .wr_req     (wr_req),
        .wr_sel     (wr_sel),
        .wr_chan    (wr_chan),
        .wr_data    (wr_data),
        .wr_ack     (wr_ack),
        .cfg        (cfg.regs)
    );

    opf_sample_timer u_sample_timer (
        .sys_clk_in (sys_clk_in),
        .sys_rst_in (sys_rst_in),
        .tick       (tick)
    );

    opf_input_buffer u_input_buffer (
        .sys_clk_in (sys_clk_in),
        .sys_rst_in (sys_rst_in),
        .dv_in      (dv_in),
        .chan_in    (chan_in),
        .data_in    (data_in),
        .pending    (pending),
        .issue      (issue.buffer)
    );

    opf_chan_sequencer u_chan_sequencer (
        .sys_clk_in  (sys_clk_in),
        .sys_rst_in  (sys_rst_in),
        .tick        (tick),
        .pending     (pending),
        .chan_rst_in (chan_rst_in),
        .issue       (issue.sequencer)
    );

    opf_output_filter u_output_filter (
        .sys_clk_in (sys_clk_in),
        .sys_rst_in (sys_rst_in),
        .issue      (issue.filter),
        .cfg        (cfg.filter),
        .dv_out     (dv_out),
        .chan_out   (chan_out),
        .data_out   (data_out)
    );

endmodule

`default_nettype wire

/* hw/opf_output_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module opf_output_filter (
    input  wire                                  sys_clk_in,
    input  wire                                  sys_rst_in,
    opf_issue_if.filter                          issue,
    opf_cfg_if.filter                            cfg,
    output logic                                 dv_out,
    output logic [opf_pkg::w_chan-1:0]           chan_out,
    output logic signed [opf_pkg::w_data_out-1:0] data_out
);
    import opf_pkg::*;

    // Previous output per channel
    logic signed [w_data_out-1:0] prev_mem [n_chan];

    // Stage 1
    logic s1_valid;
    opf_op_e s1_op;
    logic [w_chan-1:0] s1_chan;
    logic signed [w_data_in-1:0] s1_data;
    logic signed [w_mult-1:0] s1_mult;
    // Stage 2
    logic s2_valid;
    opf_op_e s2_op;
    logic [w_chan-1:0] s2_chan;
    logic signed [w_prod-1:0] s2_prod;
    logic [w_rs-1:0] s2_rs;
    logic signed [w_data_out-1:0] s2_prev;
    // Stage 3
    logic s3_valid;
    opf_op_e s3_op;
    logic [w_chan-1:0] s3_chan;
    logic signed [w_int-1:0] s3_sum;
    logic signed [w_data_out-1:0] s3_max;
    logic signed [w_data_out-1:0] s3_min;
    logic signed [w_data_out-1:0] s3_init;
    // Stage 4
    logic s4_valid;
    logic [w_chan-1:0] s4_chan;
    logic signed [w_data_out-1:0] s4_data;

    logic signed [w_prod-1:0] prod;
    logic signed [w_data_out-1:0] prev_sel;
    logic signed [w_int-1:0] shifted;
    logic signed [w_int-1:0] prev_ext;
    logic signed [w_data_out-1:0] s4_next;

    // Lookup indices follow the stage that needs them
    assign cfg.mult_chan = issue.chan;
    assign cfg.rs_chan = s1_chan;
    assign cfg.bnd_chan = s2_chan;

    assign prod = s1_data * s1_mult;

    // Newest result of the same channel wins
    always_comb begin
        prev_sel = prev_mem[s1_chan];
        if (s3_valid && s3_chan == s1_chan) begin
            prev_sel = s4_next;
        end else if (s4_valid && s4_chan == s1_chan) begin
            prev_sel = s4_data;
        end
    end

    // Sign-extended shift and add operands
    assign shifted = w_int'(s2_prod) >>> s2_rs;
    assign prev_ext = w_int'(s2_prev);

    // Clamp, or init load
    always_comb begin
        if (s3_op == op_load_init) begin
            s4_next = s3_init;
        end else if (s3_sum > w_int'(s3_max)) begin
            s4_next = s3_max;
        end else if (s3_sum < w_int'(s3_min)) begin
            s4_next = s3_min;
        end else begin
            s4_next = s3_sum[w_data_out-1:0];
        end
    end

    // ------------------------------
    // Valid pipe
    // ------------------------------
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_in) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            s4_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
            s4_valid <= s3_valid;
        end
    end

    // ------------------------------
    // Payload pipe
    // ------------------------------
    always_ff @(posedge sys_clk_in) begin
        // Stage 1 item and multiplier
        s1_op <= issue.op;
        s1_chan <= issue.chan;
        s1_data <= issue.data;
        s1_mult <= cfg.mult;
        // Stage 2 product, shift, previous output
        s2_op <= s1_op;
        s2_chan <= s1_chan;
        s2_prod <= prod;
        s2_rs <= cfg.rs;
        s2_prev <= prev_sel;
        // Stage 3 sum and bounds
        s3_op <= s2_op;
        s3_chan <= s2_chan;
        s3_sum <= shifted + prev_ext;
        s3_max <= cfg.bnd_max;
        s3_min <= cfg.bnd_min;
        s3_init <= cfg.bnd_init;
        // Stage 4 result
        s4_chan <= s3_chan;
        s4_data <= s4_next;
    end

    // Writeback from the output register
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_in) begin
            for (int i = 0; i < n_chan; i++) begin
                prev_mem[i] <= '0;
            end
        end else if (s4_valid) begin
            prev_mem[s4_chan] <= s4_data;
        end
    end

    assign dv_out = s4_valid;
    assign chan_out = s4_chan;
    assign data_out = s4_data;

endmodule

`default_nettype wire

/* hw/opf_chan_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module opf_chan_sequencer (
    input  wire                          sys_clk_in,
    input  wire                          sys_rst_in,
    input  wire                          tick,
    input  wire [opf_pkg::n_chan-1:0]    pending,
    input  wire [opf_pkg::n_chan-1:0]    chan_rst_in,
    opf_issue_if.sequencer               issue
);
    import opf_pkg::*;

    seq_state_e state;
    // Sweep position
    logic [w_chan-1:0] ptr;
    // Latched reset requests
    logic [n_chan-1:0] rst_lat;
    // Request served this cycle
    logic [n_chan-1:0] rst_clr;
    logic [w_chan-1:0] rst_idx;

    // Lowest set request bit
    function automatic logic [w_chan-1:0] lowest_set(input logic [n_chan-1:0] v);
        logic [w_chan-1:0] idx;
        idx = '0;
        for (int i = n_chan - 1; i >= 0; i--) begin
            if (v[i]) begin
                idx = w_chan'(i);
            end
        end
        return idx;
    endfunction

    assign rst_idx = lowest_set(rst_lat);

    // ------------------------------
    // Issue decode
    // ------------------------------
    always_comb begin
        issue.valid = 1'b0;
        issue.op = op_update;
        issue.chan = ptr;
        rst_clr = '0;
        case (state)
            st_reset: begin
                // One init load per cycle
                if (|rst_lat) begin
                    issue.valid = 1'b1;
                    issue.op = op_load_init;
                    issue.chan = rst_idx;
                    rst_clr = n_chan'(1) << rst_idx;
                end
            end
            st_sweep: begin
                // Skip channels with nothing new
                issue.valid = pending[ptr];
            end
            default: ;
        endcase
    end

    // ------------------------------
    // State machine
    // ------------------------------
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_in) begin
            state <= st_idle;
            ptr <= '0;
            rst_lat <= '0;
        end else begin
            rst_lat <= (rst_lat & ~rst_clr) | chan_rst_in;
            case (state)
                st_idle: begin
                    if (tick) begin
                        ptr <= '0;
                        state <= (|rst_lat) ? st_reset : st_sweep;
                    end
                end
                st_reset: begin
                    // Leaves on an empty cycle, so the last load is two ahead of the sweep
                    if (!(|rst_lat)) begin
                        ptr <= '0;
                        state <= st_sweep;
                    end
                end
                st_sweep: begin
                    ptr <= ptr + 1'b1;
                    if (ptr == w_chan'(n_chan - 1)) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/opf_input_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module opf_input_buffer (
    input  wire                               sys_clk_in,
    input  wire                               sys_rst_in,
    input  wire                               dv_in,
    input  wire [opf_pkg::w_chan-1:0]         chan_in,
    input  wire signed [opf_pkg::w_data_in-1:0] data_in,
    output logic [opf_pkg::n_chan-1:0]        pending,
    opf_issue_if.buffer                       issue
);
    import opf_pkg::*;

    // Latest sample per channel
    logic signed [w_data_in-1:0] sample_mem [n_chan];

    // Per-channel events this cycle
    logic [n_chan-1:0] arrive;
    logic [n_chan-1:0] taken;

    always_comb begin
        arrive = '0;
        taken = '0;
        if (dv_in) begin
            arrive[chan_in] = 1'b1;
        end
        // Only an update consumes a sample
        if (issue.valid && issue.op == op_update) begin
            taken[issue.chan] = 1'b1;
        end
    end

    // Sample store, new value overwrites
    always_ff @(posedge sys_clk_in) begin
        if (dv_in) begin
            sample_mem[chan_in] <= data_in;
        end
    end

    // Pending flags
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_in) begin
            pending <= '0;
        end else begin
            // Arrival wins over a same-cycle issue
            pending <= (pending & ~taken) | arrive;
        end
    end

    // Issue data read straight from the store
    assign issue.data = sample_mem[issue.chan];

endmodule

`default_nettype wire

/* hw/opf_sample_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module opf_sample_timer (
    input  wire  sys_clk_in,
    input  wire  sys_rst_in,
    output logic tick
);
    import opf_pkg::*;

    // Free-running period counter
    logic [w_tick-1:0] cnt;
    logic wrap;

    // Last count of the period
    assign wrap = (cnt == w_tick'(tick_period - 1));

    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_in) begin
            cnt <= '0;
            tick <= 1'b0;
        end else begin
            // Back to zero at the wrap
            cnt <= wrap ? '0 : cnt + 1'b1;
            // One cycle pulse per period
            tick <= wrap;
        end
    end

endmodule

`default_nettype wire

/* hw/opf_param_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module opf_param_regs (
    input  wire                            sys_clk_in,
    input  wire                            sys_rst_in,
    input  wire                            wr_req,
    input  opf_pkg::opf_reg_e              wr_sel,
    input  wire [opf_pkg::w_chan-1:0]      wr_chan,
    input  wire [opf_pkg::w_wr_data-1:0]   wr_data,
    output logic                           wr_ack,
    opf_cfg_if.regs                        cfg
);
    import opf_pkg::*;

    // ------------------------------
    // Settings storage
    // ------------------------------
    logic signed [w_mult-1:0] mult_mem [n_chan];
    logic [w_rs-1:0] rs_mem [n_chan];
    logic signed [w_data_out-1:0] max_mem [n_chan];
    logic signed [w_data_out-1:0] min_mem [n_chan];
    logic signed [w_data_out-1:0] init_mem [n_chan];

    // New request seen, ack not yet raised
    logic wr_go;

    assign wr_go = wr_req && !wr_ack;

    // ------------------------------
    // Four-phase write port
    // ------------------------------
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_in) begin
            wr_ack <= 1'b0;
            // Defaults on every channel
            for (int i = 0; i < n_chan; i++) begin
                mult_mem[i] <= def_mult;
                rs_mem[i] <= def_rs;
                max_mem[i] <= max_out;
                min_mem[i] <= min_out;
                init_mem[i] <= def_init;
            end
        end else begin
            if (wr_go) begin
                // Write once, then ack next cycle
                wr_ack <= 1'b1;
                // Field truncated to its own width
                case (wr_sel)
                    reg_mult: mult_mem[wr_chan] <= wr_data[w_mult-1:0];
                    reg_rs:   rs_mem[wr_chan] <= wr_data[w_rs-1:0];
                    reg_max:  max_mem[wr_chan] <= wr_data[w_data_out-1:0];
                    reg_min:  min_mem[wr_chan] <= wr_data[w_data_out-1:0];
                    reg_init: init_mem[wr_chan] <= wr_data[w_data_out-1:0];
                    default: ;
                endcase
            end else if (!wr_req && wr_ack) begin
                // Request gone, release ack
                wr_ack <= 1'b0;
            end
        end
    end

    // ------------------------------
    // Lookup ports
    // ------------------------------
    assign cfg.mult = mult_mem[cfg.mult_chan];
    assign cfg.rs = rs_mem[cfg.rs_chan];
    // Bounds and init share one index
    assign cfg.bnd_max = max_mem[cfg.bnd_chan];
    assign cfg.bnd_min = min_mem[cfg.bnd_chan];
    assign cfg.bnd_init = init_mem[cfg.bnd_chan];

endmodule

`default_nettype wire

/* hw/opf_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Issue path from sequencer into the filter
interface opf_issue_if;
    import opf_pkg::*;

    logic valid;
    opf_op_e op;
    logic [w_chan-1:0] chan;
    // Stored sample of chan, returned by the buffer
    logic signed [w_data_in-1:0] data;

    modport sequencer (output valid, output op, output chan);
    modport buffer (input valid, input op, input chan, output data);
    modport filter (input valid, input op, input chan, input data);
endinterface

// Settings lookup, three independent read ports
interface opf_cfg_if;
    import opf_pkg::*;

    // Stage 1 lookup
    logic [w_chan-1:0] mult_chan;
    logic signed [w_mult-1:0] mult;
    // Stage 2 lookup
    logic [w_chan-1:0] rs_chan;
    logic [w_rs-1:0] rs;
    // Stage 3 lookup
    logic [w_chan-1:0] bnd_chan;
    logic signed [w_data_out-1:0] bnd_max;
    logic signed [w_data_out-1:0] bnd_min;
    logic signed [w_data_out-1:0] bnd_init;

    modport regs (
        input mult_chan, input rs_chan, input bnd_chan,
        output mult, output rs, output bnd_max, output bnd_min, output bnd_init
    );
    modport filter (
        output mult_chan, output rs_chan, output bnd_chan,
        input mult, input rs, input bnd_max, input bnd_min, input bnd_init
    );
endinterface

`default_nettype wire

/* hw/opf_pkg.sv */
`default_nettype none

package opf_pkg;

    // ------------------------------
    // Widths and counts
    // ------------------------------
    localparam int n_chan = 8;
    localparam int w_chan = 3;
    localparam int w_data_in = 18;
    localparam int w_data_out = 24;
    localparam int w_mult = 8;
    localparam int w_rs = 5;
    localparam int w_wr_data = 24;

    // Product of sample and multiplier
    localparam int w_prod = w_data_in + w_mult;
    // One guard bit over the wider of product and output
    localparam int w_int = ((w_prod > w_data_out) ? w_prod : w_data_out) + 1;

    // Update rate
    localparam int tick_period = 32;
    localparam int w_tick = $clog2(tick_period);

    // Full signed output range
    localparam logic signed [w_data_out-1:0] max_out = {1'b0, {(w_data_out-1){1'b1}}};
    localparam logic signed [w_data_out-1:0] min_out = {1'b1, {(w_data_out-1){1'b0}}};

    // Per-channel defaults after reset
    localparam logic signed [w_mult-1:0] def_mult = 1;
    localparam logic [w_rs-1:0] def_rs = '0;
    localparam logic signed [w_data_out-1:0] def_init = '0;

    // ------------------------------
    // Encodings
    // ------------------------------
    // Host register select
    typedef enum logic [2:0] {
        reg_mult = 3'd0,
        reg_rs   = 3'd1,
        reg_max  = 3'd2,
        reg_min  = 3'd3,
        reg_init = 3'd4
    } opf_reg_e;

    // Operation carried by an issued item
    typedef enum logic {
        op_update    = 1'b0,
        op_load_init = 1'b1
    } opf_op_e;

    // Sequencer states
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_reset = 2'd1,
        st_sweep = 2'd2
    } seq_state_e;

endpackage

`default_nettype wire
